/* list.f */
hdl/riscv32b_pkg.sv
hdl/registers.sv
hdl/ifetch.sv
hdl/idecode.sv
hdl/exe.sv
hdl/lsu.sv
hdl/riscv32b.sv
test/tb_checker.sv
test/tb_riscv32b.sv

/* test/tb_riscv32b.sv */
`timescale 1ns/1ps

module tb_riscv32b;

  localparam logic [31:0] RESET_PC   = 32'h0000_0000;
  localparam int          END_IDX    = 240;
  localparam int          JALR_IDX   = 100;
  localparam int          MAX_CYCLES = 1000;
  localparam logic [31:0] END_PC     = RESET_PC + 32'(END_IDX * 4);

  logic        clk;
  logic        reset;
  logic [31:0] instr_addr;
  logic        instr_rd;
  logic [31:0] instr_in;
  logic [31:0] data_addr;
  logic        datamem_rd;
  logic [3:0]  datamem_wr;
  logic [31:0] data_in;
  logic [7:0]  data_out0;
  logic [7:0]  data_out1;
  logic [7:0]  data_out2;
  logic [7:0]  data_out3;

  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:63];
  logic [31:0] rng;
  int          cycles;
  int          timeouts;
  int          i;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  assign instr_in = imem[instr_addr[9:2]];
  assign data_in  = dmem[data_addr[7:2]];

  always @(posedge clk) begin
    if (datamem_wr[0]) dmem[data_addr[7:2]][7:0] <= data_out0;
    if (datamem_wr[1]) dmem[data_addr[7:2]][15:8] <= data_out1;
    if (datamem_wr[2]) dmem[data_addr[7:2]][23:16] <= data_out2;
    if (datamem_wr[3]) dmem[data_addr[7:2]][31:24] <= data_out3;
  end

  riscv32b #(
    .RESET_PC (RESET_PC)
  ) UUT (
    .clk        (clk),
    .reset      (reset),
    .instr_addr (instr_addr),
    .instr_rd   (instr_rd),
    .instr_in   (instr_in),
    .data_addr  (data_addr),
    .datamem_rd (datamem_rd),
    .datamem_wr (datamem_wr),
    .data_in    (data_in),
    .data_out0  (data_out0),
    .data_out1  (data_out1),
    .data_out2  (data_out2),
    .data_out3  (data_out3)
  );

  tb_checker #(
    .RESET_PC (RESET_PC)
  ) CHK (
    .clk        (clk),
    .reset      (reset),
    .instr_addr (instr_addr),
    .instr_rd   (instr_rd),
    .instr_in   (instr_in),
    .data_addr  (data_addr),
    .datamem_rd (datamem_rd),
    .datamem_wr (datamem_wr),
    .data_out0  (data_out0),
    .data_out1  (data_out1),
    .data_out2  (data_out2),
    .data_out3  (data_out3)
  );

  function automatic logic [31:0] lcg_next();
    rng = rng * 32'd1103515245 + 32'd12345;
    return rng;
  endfunction

  function automatic int unsigned pick(input int unsigned n);
    logic [31:0] r;
    r = lcg_next();
    return (r >> 8) % n;
  endfunction

  // Any destination except x1, which holds the data base.
  function automatic logic [4:0] pick_rd();
    int unsigned r;
    r = pick(31);
    if (r >= 1) r = r + 1;
    return 5'(r);
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] make_random_instr(input int idx);
    int unsigned kind;
    int unsigned d;
    int unsigned sel;
    int unsigned size;
    int unsigned off;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic [31:0] r;
    bit          fwd_ok;
    kind = pick(15);
    rd = pick_rd();
    rs1 = 5'(pick(32));
    rs2 = 5'(pick(32));
    f3 = 3'(pick(8));
    d = 2 + pick(3);
    // Forward jumps must not land inside the JALR pair.
    fwd_ok = ((idx + 4) <= JALR_IDX) || ((idx > JALR_IDX) && ((idx + 4) <= END_IDX));
    case (kind)
      0, 1, 2, 3: begin
        imm = 12'(pick(4096));
        if (f3 == 3'b001) imm = {7'b0, imm[4:0]};
        if (f3 == 3'b101) imm = {1'b0, imm[10], 5'b0, imm[4:0]};
        return enc_i(imm, rs1, f3, rd, riscv32b_pkg::OPC_OP_IMM);
      end
      4, 5, 6: begin
        f7 = (((f3 == 3'b000) || (f3 == 3'b101)) && (pick(2) == 1)) ? 7'h20 : 7'h00;
        return {f7, rs2, rs1, f3, rd, riscv32b_pkg::OPC_OP};
      end
      7: begin
        r = lcg_next();
        return {r[31:12], rd, riscv32b_pkg::OPC_LUI};
      end
      8: begin
        r = lcg_next();
        return {r[31:12], rd, riscv32b_pkg::OPC_AUIPC};
      end
      9, 10: begin
        sel = pick(5);
        f3 = (sel < 3) ? 3'(sel) : 3'(sel + 1);
        size = 1 << f3[1:0];
        off = pick(256) & ~(size - 1);
        return enc_i(12'(off), 5'd1, f3, rd, riscv32b_pkg::OPC_LOAD);
      end
      11, 12: begin
        f3 = 3'(pick(3));
        size = 1 << f3[1:0];
        off = pick(256) & ~(size - 1);
        return enc_s(12'(off), rs2, 5'd1, f3);
      end
      13: begin
        sel = pick(6);
        f3 = (sel < 2) ? 3'(sel) : 3'(sel + 2);
        if (fwd_ok) return enc_b(13'(d * 4), rs2, rs1, f3);
      end
      default: begin
        if (fwd_ok) return enc_j(21'(d * 4), rd);
      end
    endcase
    return enc_i(12'(pick(4096)), rs1, 3'b000, rd, riscv32b_pkg::OPC_OP_IMM);
  endfunction

  task automatic build_program();
    int idx;
    imem[0] = {20'h00001, 5'd1, riscv32b_pkg::OPC_LUI};
    idx = 1;
    while (idx < END_IDX) begin
      if (idx == JALR_IDX) begin
        // Target is pc+13 with bit 0 cleared, which skips the addi.
        imem[idx] = {20'h0, 5'd5, riscv32b_pkg::OPC_AUIPC};
        imem[idx + 1] = enc_i(12'd13, 5'd5, 3'b000, 5'd6, riscv32b_pkg::OPC_JALR);
        imem[idx + 2] = enc_i(12'd1, 5'd0, 3'b000, 5'd7, riscv32b_pkg::OPC_OP_IMM);
        idx = idx + 3;
      end else begin
        imem[idx] = make_random_instr(idx);
        idx = idx + 1;
      end
    end
    for (idx = END_IDX; idx < 256; idx++) begin
      imem[idx] = enc_j(21'd0, 5'd0);
    end
  endtask

  initial begin
    reset = 1'b1;
    rng = 32'd60505;
    cycles = 0;
    timeouts = 0;
    build_program();
    for (i = 0; i < 64; i++) begin
      dmem[i] = (32'h9E37_79B9 * 32'(i + 1)) ^ (32'(i) << 26);
      CHK.load_word(i, dmem[i]);
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    while (!((instr_rd === 1'b1) && (instr_addr == END_PC)) && (cycles < MAX_CYCLES)) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles >= MAX_CYCLES) begin
      timeouts = 1;
      $display("Timeout: the program never reached its final self-loop");
    end
    repeat (2) @(negedge clk);
    for (i = 0; i < 64; i++) begin
      CHK.check_word(i, dmem[i]);
    end
    $display("Run finished: %0d mismatch errors, %0d timeouts", CHK.error_count, timeouts);
    if ((CHK.error_count == 0) && (timeouts == 0)) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* test/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker #(
  parameter logic [31:0] RESET_PC = '0
) (
  input logic        clk,
  input logic        reset,
  input logic [31:0] instr_addr,
  input logic        instr_rd,
  input logic [31:0] instr_in,
  input logic [31:0] data_addr,
  input logic        datamem_rd,
  input logic [3:0]  datamem_wr,
  input logic [7:0]  data_out0,
  input logic [7:0]  data_out1,
  input logic [7:0]  data_out2,
  input logic [7:0]  data_out3
);

  logic [31:0] xreg [0:31];
  logic [31:0] model_mem [0:63];
  logic [31:0] model_pc;
  int          error_count = 0;
  int          reset_edges = 0;
  bit          started = 0;

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
    end
  endtask

  task automatic load_word(input int idx, input logic [31:0] value);
    model_mem[idx] = value;
  endtask

  task automatic check_word(input int idx, input logic [31:0] actual);
    compare_value($sformatf("dmem[%0d]", idx), model_mem[idx], actual);
  endtask

  task automatic clear_model();
    int i;
    for (i = 0; i < 32; i++) begin
      xreg[i] = '0;
    end
    model_pc = RESET_PC;
  endtask

  function automatic logic branch_holds(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      3'b111:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Shift amounts use the low five bits of the second operand.
  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic reg_form, input logic [31:0] x,
                                            input logic [31:0] y);
    logic [31:0] r;
    case (f3)
      3'b000:  r = (alt && reg_form) ? x - y : x + y;
      3'b001:  r = x << y[4:0];
      3'b010:  r = {31'd0, $signed(x) < $signed(y)};
      3'b011:  r = {31'd0, x < y};
      3'b100:  r = x ^ y;
      3'b101: begin
        r = x >> y[4:0];
        if (alt && x[31]) begin
          // Fill the vacated high bits with the sign.
          r = r | ~(32'hFFFF_FFFF >> y[4:0]);
        end
      end
      3'b110:  r = x | y;
      default: r = x & y;
    endcase
    return r;
  endfunction

  task automatic execute_step();
    logic [31:0] ins;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] result;
    logic [31:0] next_pc;
    logic [31:0] addr;
    logic [31:0] sh;
    logic [31:0] lanes;
    logic [3:0]  exp_wr;
    logic        write_rd;
    logic        is_load;
    logic        is_store;
    int          k;
    compare_value("instr_rd", 32'd1, {31'd0, instr_rd});
    compare_value("instr_addr", model_pc, instr_addr);
    ins = instr_in;
    opc = ins[6:0];
    f3 = ins[14:12];
    rd = ins[11:7];
    a = xreg[ins[19:15]];
    b = xreg[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u = {ins[31:12], 12'b0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    next_pc = model_pc + 32'd4;
    result = '0;
    addr = '0;
    lanes = '0;
    exp_wr = '0;
    write_rd = 1'b0;
    is_load = 1'b0;
    is_store = 1'b0;
    case (opc)
      riscv32b_pkg::OPC_LUI: begin
        result = imm_u;
        write_rd = 1'b1;
      end
      riscv32b_pkg::OPC_AUIPC: begin
        result = model_pc + imm_u;
        write_rd = 1'b1;
      end
      riscv32b_pkg::OPC_JAL: begin
        result = model_pc + 32'd4;
        write_rd = 1'b1;
        next_pc = model_pc + imm_j;
      end
      riscv32b_pkg::OPC_JALR: begin
        result = model_pc + 32'd4;
        write_rd = 1'b1;
        next_pc = (a + imm_i) & ~32'd1;
      end
      riscv32b_pkg::OPC_BRANCH: begin
        if (branch_holds(f3, a, b)) begin
          next_pc = model_pc + imm_b;
        end
      end
      riscv32b_pkg::OPC_LOAD: begin
        addr = a + imm_i;
        sh = model_mem[addr[7:2]] >> {addr[1:0], 3'b000};
        is_load = 1'b1;
        write_rd = 1'b1;
        case (f3)
          3'b000:  result = {{24{sh[7]}}, sh[7:0]};
          3'b001:  result = {{16{sh[15]}}, sh[15:0]};
          3'b100:  result = {24'd0, sh[7:0]};
          3'b101:  result = {16'd0, sh[15:0]};
          default: result = model_mem[addr[7:2]];
        endcase
      end
      riscv32b_pkg::OPC_STORE: begin
        addr = a + imm_s;
        is_store = 1'b1;
        case (f3)
          3'b000: begin
            lanes = {4{b[7:0]}};
            exp_wr = 4'b0001 << addr[1:0];
          end
          3'b001: begin
            lanes = {2{b[15:0]}};
            exp_wr = addr[1] ? 4'b1100 : 4'b0011;
          end
          default: begin
            lanes = b;
            exp_wr = 4'b1111;
          end
        endcase
      end
      riscv32b_pkg::OPC_OP_IMM: begin
        result = alu_model(f3, ins[30], 1'b0, a, imm_i);
        write_rd = 1'b1;
      end
      riscv32b_pkg::OPC_OP: begin
        result = alu_model(f3, ins[30], 1'b1, a, b);
        write_rd = 1'b1;
      end
      default: begin
        $display("Checker met an opcode it does not model at pc 0x%08h", model_pc);
        error_count++;
      end
    endcase
    compare_value("datamem_rd", {31'd0, is_load}, {31'd0, datamem_rd});
    compare_value("datamem_wr", {28'd0, exp_wr}, {28'd0, datamem_wr});
    if (is_load || is_store) begin
      compare_value("data_addr", {addr[31:2], 2'b00}, data_addr);
    end
    if (is_store) begin
      compare_value("data_out", lanes, {data_out3, data_out2, data_out1, data_out0});
      for (k = 0; k < 4; k++) begin
        if (exp_wr[k]) begin
          model_mem[addr[7:2]][8*k +: 8] = lanes[8*k +: 8];
        end
      end
    end
    if (write_rd && (rd != 5'd0)) begin
      xreg[rd] = result;
    end
    model_pc = next_pc;
  endtask

  // Ports are sampled at the rising edge before the DUT state moves.
  always @(posedge clk) begin
    if (reset) begin
      clear_model();
      started = 1'b0;
      if (reset_edges > 0) begin
        compare_value("instr_rd", 32'd0, {31'd0, instr_rd});
        compare_value("datamem_rd", 32'd0, {31'd0, datamem_rd});
        compare_value("datamem_wr", 32'd0, {28'd0, datamem_wr});
      end
      reset_edges++;
    end else if (!started) begin
      // First cycle after reset only restarts the fetch.
      started = 1'b1;
      compare_value("datamem_rd", 32'd0, {31'd0, datamem_rd});
      compare_value("datamem_wr", 32'd0, {28'd0, datamem_wr});
    end else begin
      execute_step();
    end
  end

endmodule

/* hdl/riscv32b.sv */
`timescale 1ns/1ps

module riscv32b #(
  parameter logic [riscv32b_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic        clk,
  input  logic        reset,
  output logic [31:0] instr_addr,
  output logic        instr_rd,
  input  logic [31:0] instr_in,
  output logic [31:0] data_addr,
  output logic        datamem_rd,
  output logic [3:0]  datamem_wr,
  input  logic [31:0] data_in,
  output logic [7:0]  data_out0,
  output logic [7:0]  data_out1,
  output logic [7:0]  data_out2,
  output logic [7:0]  data_out3
);

  // addi x0, x0, 0
  localparam logic [riscv32b_pkg::XLEN-1:0] NOP = 32'h0000_0013;

  logic                                reset_q;
  logic                                pc_hold;
  logic [riscv32b_pkg::XLEN-1:0]       instr;
  logic                                reg_wr;
  riscv32b_pkg::wb_e                   wb_sel;
  riscv32b_pkg::load_e                 load_type;
  riscv32b_pkg::store_e                store_type;
  riscv32b_pkg::alu_a_e                alu_a_sel;
  riscv32b_pkg::alu_b_e                alu_b_sel;
  riscv32b_pkg::alu_op_e               alu_op;
  riscv32b_pkg::branch_e               branch_type;
  logic                                jal;
  logic                                jalr;
  logic [riscv32b_pkg::XLEN-1:0]       imm;
  logic [riscv32b_pkg::XLEN-1:0]       rs1_data;
  logic [riscv32b_pkg::XLEN-1:0]       rs2_data;
  logic [riscv32b_pkg::XLEN-1:0]       alu_result;
  logic                                branch_taken;
  logic [riscv32b_pkg::XLEN-1:0]       store_lanes;
  logic [riscv32b_pkg::XLEN-1:0]       reg_wrdata;

  always_ff @(posedge clk) begin
    reset_q <= reset;
  end

  // The core starts fetching one cycle after reset is released.
  assign instr_rd = ~reset_q;
  assign pc_hold  = reset | reset_q;
  assign instr    = instr_rd ? instr_in : NOP;

  assign data_out0 = store_lanes[7:0];
  assign data_out1 = store_lanes[15:8];
  assign data_out2 = store_lanes[23:16];
  assign data_out3 = store_lanes[31:24];

  registers regset (
    .clk      (clk),
    .reset    (reset),
    .write    (reg_wr),
    .rs1_addr (instr[19:15]),
    .rs2_addr (instr[24:20]),
    .w_addr   (instr[11:7]),
    .w_data   (reg_wrdata),
    .rs1_out  (rs1_data),
    .rs2_out  (rs2_data)
  );

  ifetch #(
    .RESET_PC (RESET_PC)
  ) fetchunit (
    .clk          (clk),
    .reset        (pc_hold),
    .rs1          (rs1_data),
    .immediate    (imm),
    .jal          (jal),
    .jalr         (jalr),
    .pcbranch     (branch_taken),
    .instr_addr_o (instr_addr)
  );

  idecode decodeunit (
    .instr       (instr),
    .reg_wr      (reg_wr),
    .wb_sel      (wb_sel),
    .load_type   (load_type),
    .store_type  (store_type),
    .alu_a_sel   (alu_a_sel),
    .alu_b_sel   (alu_b_sel),
    .alu_op      (alu_op),
    .branch_type (branch_type),
    .jal         (jal),
    .jalr        (jalr),
    .imm         (imm)
  );

  exe exeunit (
    .imm          (imm),
    .alu_a_sel    (alu_a_sel),
    .alu_b_sel    (alu_b_sel),
    .alu_op       (alu_op),
    .rs1          (rs1_data),
    .rs2          (rs2_data),
    .pc           (instr_addr),
    .branch_type  (branch_type),
    .alu_result   (alu_result),
    .branch_taken (branch_taken)
  );

  lsu lsuunit (
    .alu_result  (alu_result),
    .pc          (instr_addr),
    .wb_sel      (wb_sel),
    .load_type   (load_type),
    .store_type  (store_type),
    .store_data  (rs2_data),
    .load_data   (data_in),
    .data_addr   (data_addr),
    .datamem_rd  (datamem_rd),
    .datamem_wr  (datamem_wr),
    .store_lanes (store_lanes),
    .reg_wrdata  (reg_wrdata)
  );

endmodule

/* hdl/lsu.sv */
`timescale 1ns/1ps

module lsu (
  input  logic [riscv32b_pkg::XLEN-1:0] alu_result,
  input  logic [riscv32b_pkg::XLEN-1:0] pc,
  input  riscv32b_pkg::wb_e             wb_sel,
  input  riscv32b_pkg::load_e           load_type,
  input  riscv32b_pkg::store_e          store_type,
  input  logic [riscv32b_pkg::XLEN-1:0] store_data,
  input  logic [riscv32b_pkg::XLEN-1:0] load_data,
  output logic [riscv32b_pkg::XLEN-1:0] data_addr,
  output logic                          datamem_rd,
  output logic [3:0]                    datamem_wr,
  output logic [riscv32b_pkg::XLEN-1:0] store_lanes,
  output logic [riscv32b_pkg::XLEN-1:0] reg_wrdata
);

  logic [1:0]                    byte_off;
  logic [riscv32b_pkg::XLEN-1:0] shifted;
  logic [riscv32b_pkg::XLEN-1:0] load_value;

  assign byte_off   = alu_result[1:0];
  assign data_addr  = {alu_result[riscv32b_pkg::XLEN-1:2], 2'b00};
  assign datamem_rd = (load_type != riscv32b_pkg::LD_NONE);

  // Narrow stores are copied to every lane, the enables pick the target.
  always_comb begin
    case (store_type)
      riscv32b_pkg::ST_SB: begin
        store_lanes = {4{store_data[7:0]}};
        datamem_wr  = 4'b0001 << byte_off;
      end
      riscv32b_pkg::ST_SH: begin
        store_lanes = {2{store_data[15:0]}};
        datamem_wr  = byte_off[1] ? 4'b1100 : 4'b0011;
      end
      riscv32b_pkg::ST_SW: begin
        store_lanes = store_data;
        datamem_wr  = 4'b1111;
      end
      default: begin
        store_lanes = store_data;
        datamem_wr  = 4'b0000;
      end
    endcase
  end

  assign shifted = load_data >> {byte_off, 3'b000};

  always_comb begin
    case (load_type)
      riscv32b_pkg::LD_LB:  load_value = {{24{shifted[7]}}, shifted[7:0]};
      riscv32b_pkg::LD_LH:  load_value = {{16{shifted[15]}}, shifted[15:0]};
      riscv32b_pkg::LD_LW:  load_value = load_data;
      riscv32b_pkg::LD_LBU: load_value = {24'b0, shifted[7:0]};
      riscv32b_pkg::LD_LHU: load_value = {16'b0, shifted[15:0]};
      default:              load_value = '0;
    endcase
  end

  always_comb begin
    case (wb_sel)
      riscv32b_pkg::WB_LOAD:     reg_wrdata = load_value;
      riscv32b_pkg::WB_PC_PLUS4: reg_wrdata = pc + riscv32b_pkg::XLEN'(4);
      default:                   reg_wrdata = alu_result;
    endcase
  end

  // Load and store controls come from one decoded instruction.
  always_comb begin
    assert #0 (!(datamem_rd && (datamem_wr != 4'b0000)));
  end

endmodule

/* hdl/exe.sv */
`timescale 1ns/1ps

module exe (
  input  logic [riscv32b_pkg::XLEN-1:0] imm,
  input  riscv32b_pkg::alu_a_e          alu_a_sel,
  input  riscv32b_pkg::alu_b_e          alu_b_sel,
  input  riscv32b_pkg::alu_op_e         alu_op,
  input  logic [riscv32b_pkg::XLEN-1:0] rs1,
  input  logic [riscv32b_pkg::XLEN-1:0] rs2,
  input  logic [riscv32b_pkg::XLEN-1:0] pc,
  input  riscv32b_pkg::branch_e         branch_type,
  output logic [riscv32b_pkg::XLEN-1:0] alu_result,
  output logic                          branch_taken
);

  localparam int SHAMT_W = $clog2(riscv32b_pkg::XLEN);

  logic [riscv32b_pkg::XLEN-1:0] op_a;
  logic [riscv32b_pkg::XLEN-1:0] op_b;
  logic [SHAMT_W-1:0]            shamt;
  logic                          rs_eq;
  logic                          rs_lt;
  logic                          rs_ltu;

  always_comb begin
    case (alu_a_sel)
      riscv32b_pkg::A_RS1: op_a = rs1;
      riscv32b_pkg::A_PC:  op_a = pc;
      default:             op_a = '0;
    endcase
  end

  assign op_b  = (alu_b_sel == riscv32b_pkg::B_IMM) ? imm : rs2;
  assign shamt = op_b[SHAMT_W-1:0];

  always_comb begin
    case (alu_op)
      riscv32b_pkg::ALU_ADD:    alu_result = op_a + op_b;
      riscv32b_pkg::ALU_SUB:    alu_result = op_a - op_b;
      riscv32b_pkg::ALU_SLL:    alu_result = op_a << shamt;
      riscv32b_pkg::ALU_SLT: begin
        alu_result = riscv32b_pkg::XLEN'($signed(op_a) < $signed(op_b));
      end
      riscv32b_pkg::ALU_SLTU:   alu_result = riscv32b_pkg::XLEN'(op_a < op_b);
      riscv32b_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
      riscv32b_pkg::ALU_SRL:    alu_result = op_a >> shamt;
      riscv32b_pkg::ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> shamt);
      riscv32b_pkg::ALU_OR:     alu_result = op_a | op_b;
      riscv32b_pkg::ALU_AND:    alu_result = op_a & op_b;
      riscv32b_pkg::ALU_PASS_B: alu_result = op_b;
      default:                  alu_result = '0;
    endcase
  end

  // Branch compare works on the raw register operands.
  assign rs_eq  = (rs1 == rs2);
  assign rs_lt  = ($signed(rs1) < $signed(rs2));
  assign rs_ltu = (rs1 < rs2);

  always_comb begin
    case (branch_type)
      riscv32b_pkg::BR_EQ:  branch_taken = rs_eq;
      riscv32b_pkg::BR_NE:  branch_taken = !rs_eq;
      riscv32b_pkg::BR_LT:  branch_taken = rs_lt;
      riscv32b_pkg::BR_GE:  branch_taken = !rs_lt;
      riscv32b_pkg::BR_LTU: branch_taken = rs_ltu;
      riscv32b_pkg::BR_GEU: branch_taken = !rs_ltu;
      default:              branch_taken = 1'b0;
    endcase
  end

endmodule

/* hdl/idecode.sv */
`timescale 1ns/1ps

module idecode (
  input  logic [riscv32b_pkg::XLEN-1:0] instr,
  output logic                          reg_wr,
  output riscv32b_pkg::wb_e             wb_sel,
  output riscv32b_pkg::load_e           load_type,
  output riscv32b_pkg::store_e          store_type,
  output riscv32b_pkg::alu_a_e          alu_a_sel,
  output riscv32b_pkg::alu_b_e          alu_b_sel,
  output riscv32b_pkg::alu_op_e         alu_op,
  output riscv32b_pkg::branch_e         branch_type,
  output logic                          jal,
  output logic                          jalr,
  output logic [riscv32b_pkg::XLEN-1:0] imm
);

  riscv32b_pkg::opcode_e                 opcode;
  logic [riscv32b_pkg::FUNCT3_W-1:0]     funct3;
  logic [riscv32b_pkg::FUNCT7_W-1:0]     funct7;
  logic [riscv32b_pkg::XLEN-1:0]         imm_i;
  logic [riscv32b_pkg::XLEN-1:0]         imm_s;
  logic [riscv32b_pkg::XLEN-1:0]         imm_b;
  logic [riscv32b_pkg::XLEN-1:0]         imm_u;
  logic [riscv32b_pkg::XLEN-1:0]         imm_j;

  // funct7[5] selects SUB and SRA; SUB exists only in register form.
  function automatic riscv32b_pkg::alu_op_e arith_op(
    input logic [riscv32b_pkg::FUNCT3_W-1:0] f3,
    input logic                              alt,
    input logic                              reg_form
  );
    riscv32b_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = (alt && reg_form) ? riscv32b_pkg::ALU_SUB : riscv32b_pkg::ALU_ADD;
      3'b001:  op = riscv32b_pkg::ALU_SLL;
      3'b010:  op = riscv32b_pkg::ALU_SLT;
      3'b011:  op = riscv32b_pkg::ALU_SLTU;
      3'b100:  op = riscv32b_pkg::ALU_XOR;
      3'b101:  op = alt ? riscv32b_pkg::ALU_SRA : riscv32b_pkg::ALU_SRL;
      3'b110:  op = riscv32b_pkg::ALU_OR;
      default: op = riscv32b_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = riscv32b_pkg::opcode_e'(instr[riscv32b_pkg::OPCODE_W-1:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    // Anything not listed falls through as a no-op.
    reg_wr      = 1'b0;
    wb_sel      = riscv32b_pkg::WB_ALU;
    load_type   = riscv32b_pkg::LD_NONE;
    store_type  = riscv32b_pkg::ST_NONE;
    alu_a_sel   = riscv32b_pkg::A_RS1;
    alu_b_sel   = riscv32b_pkg::B_IMM;
    alu_op      = riscv32b_pkg::ALU_ADD;
    branch_type = riscv32b_pkg::BR_NONE;
    jal         = 1'b0;
    jalr        = 1'b0;
    imm         = imm_i;
    case (opcode)
      riscv32b_pkg::OPC_LUI: begin
        reg_wr    = 1'b1;
        alu_a_sel = riscv32b_pkg::A_ZERO;
        alu_op    = riscv32b_pkg::ALU_PASS_B;
        imm       = imm_u;
      end
      riscv32b_pkg::OPC_AUIPC: begin
        reg_wr    = 1'b1;
        alu_a_sel = riscv32b_pkg::A_PC;
        imm       = imm_u;
      end
      riscv32b_pkg::OPC_JAL: begin
        reg_wr = 1'b1;
        wb_sel = riscv32b_pkg::WB_PC_PLUS4;
        jal    = 1'b1;
        imm    = imm_j;
      end
      riscv32b_pkg::OPC_JALR: begin
        reg_wr = 1'b1;
        wb_sel = riscv32b_pkg::WB_PC_PLUS4;
        jalr   = 1'b1;
      end
      riscv32b_pkg::OPC_BRANCH: begin
        alu_b_sel = riscv32b_pkg::B_RS2;
        alu_op    = riscv32b_pkg::ALU_SUB;
        imm       = imm_b;
        case (funct3)
          3'b000:  branch_type = riscv32b_pkg::BR_EQ;
          3'b001:  branch_type = riscv32b_pkg::BR_NE;
          3'b100:  branch_type = riscv32b_pkg::BR_LT;
          3'b101:  branch_type = riscv32b_pkg::BR_GE;
          3'b110:  branch_type = riscv32b_pkg::BR_LTU;
          3'b111:  branch_type = riscv32b_pkg::BR_GEU;
          default: branch_type = riscv32b_pkg::BR_NONE;
        endcase
      end
      riscv32b_pkg::OPC_LOAD: begin
        wb_sel = riscv32b_pkg::WB_LOAD;
        case (funct3)
          3'b000:  load_type = riscv32b_pkg::LD_LB;
          3'b001:  load_type = riscv32b_pkg::LD_LH;
          3'b010:  load_type = riscv32b_pkg::LD_LW;
          3'b100:  load_type = riscv32b_pkg::LD_LBU;
          3'b101:  load_type = riscv32b_pkg::LD_LHU;
          default: load_type = riscv32b_pkg::LD_NONE;
        endcase
        reg_wr = (load_type != riscv32b_pkg::LD_NONE);
      end
      riscv32b_pkg::OPC_STORE: begin
        imm = imm_s;
        case (funct3)
          3'b000:  store_type = riscv32b_pkg::ST_SB;
          3'b001:  store_type = riscv32b_pkg::ST_SH;
          3'b010:  store_type = riscv32b_pkg::ST_SW;
          default: store_type = riscv32b_pkg::ST_NONE;
        endcase
      end
      riscv32b_pkg::OPC_OP_IMM: begin
        reg_wr = 1'b1;
        alu_op = arith_op(funct3, funct7[5], 1'b0);
      end
      riscv32b_pkg::OPC_OP: begin
        reg_wr    = 1'b1;
        alu_b_sel = riscv32b_pkg::B_RS2;
        alu_op    = arith_op(funct3, funct7[5], 1'b1);
      end
      default: begin
        reg_wr = 1'b0;
      end
    endcase
  end

endmodule

/* hdl/ifetch.sv */
`timescale 1ns/1ps

module ifetch #(
  parameter logic [riscv32b_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [riscv32b_pkg::XLEN-1:0] rs1,
  input  logic [riscv32b_pkg::XLEN-1:0] immediate,
  input  logic                          jal,
  input  logic                          jalr,
  input  logic                          pcbranch,
  output logic [riscv32b_pkg::XLEN-1:0] instr_addr_o
);

  logic [riscv32b_pkg::XLEN-1:0] pc;
  logic [riscv32b_pkg::XLEN-1:0] pc_next;
  logic [riscv32b_pkg::XLEN-1:0] jalr_target;

  assign jalr_target = (rs1 + immediate) & ~riscv32b_pkg::XLEN'(1);

  // JALR wins over pc-relative jumps and taken branches.
  always_comb begin
    if (jalr) begin
      pc_next = jalr_target;
    end else if (jal || pcbranch) begin
      pc_next = pc + immediate;
    end else begin
      pc_next = pc + riscv32b_pkg::XLEN'(4);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  assign instr_addr_o = pc;

  assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

/* hdl/registers.sv */
`timescale 1ns/1ps

module registers (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  write,
  input  logic [riscv32b_pkg::REG_ADDR_W-1:0]   rs1_addr,
  input  logic [riscv32b_pkg::REG_ADDR_W-1:0]   rs2_addr,
  input  logic [riscv32b_pkg::REG_ADDR_W-1:0]   w_addr,
  input  logic [riscv32b_pkg::XLEN-1:0]         w_data,
  output logic [riscv32b_pkg::XLEN-1:0]         rs1_out,
  output logic [riscv32b_pkg::XLEN-1:0]         rs2_out
);

  // x0 has no storage.
  logic [riscv32b_pkg::XLEN-1:0] regs [1:2**riscv32b_pkg::REG_ADDR_W-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 2**riscv32b_pkg::REG_ADDR_W; i++) begin
        regs[i] <= '0;
      end
    end else if (write && (w_addr != '0)) begin
      regs[w_addr] <= w_data;
    end
  end

  assign rs1_out = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_out = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* hdl/riscv32b_pkg.sv */
package riscv32b_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int OPCODE_W   = 7;
  localparam int FUNCT3_W   = 3;
  localparam int FUNCT7_W   = 7;

  // RV32I major opcodes handled by the core.
  typedef enum logic [OPCODE_W-1:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU
  } branch_e;

  typedef enum logic [2:0] {
    LD_NONE,
    LD_LB,
    LD_LH,
    LD_LW,
    LD_LBU,
    LD_LHU
  } load_e;

  typedef enum logic [1:0] {
    ST_NONE,
    ST_SB,
    ST_SH,
    ST_SW
  } store_e;

  typedef enum logic [1:0] {
    A_RS1,
    A_PC,
    A_ZERO
  } alu_a_e;

  typedef enum logic {
    B_RS2,
    B_IMM
  } alu_b_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_PC_PLUS4
  } wb_e;

endpackage
